/* pe_bus_cfg.svh */
`ifndef PE_BUS_CFG_SVH
`define PE_BUS_CFG_SVH

// Bus widths
`define PE_ADDR_W 32
`define PE_DATA_W 32
`define PE_OFFS_W 24

// Region codes in the top address byte
`define PE_RGN_DMEM 8'h01
`define PE_RGN_RTC  8'h02
`define PE_RGN_PLIC 8'h04
`define PE_RGN_NI   8'h08

// DMA bank codes
`define PE_BANK_IMEM 8'h00
`define PE_BANK_DMEM 8'h01

// RTC register byte offsets
`define PE_RTC_MTIME_LO 32'h0
`define PE_RTC_MTIME_HI 32'h4
`define PE_RTC_CMP_LO   32'h8
`define PE_RTC_CMP_HI   32'hC

// Interrupt controller register byte offsets
`define PE_PLIC_ENABLE  32'h0
`define PE_PLIC_PENDING 32'h4

// Bit positions in the core interrupt vector
`define PE_IRQ_MTI_BIT 7
`define PE_IRQ_MEI_BIT 11

`endif

/* pe_bus_pkg.sv */
`include "pe_bus_cfg.svh"

package pe_bus_pkg;

    // Region view: top byte selects the peripheral
    typedef struct packed {
        logic [`PE_ADDR_W-`PE_OFFS_W-1:0] region;
        logic [`PE_OFFS_W-1:0]            offset;
    } rgn_view_t;

    // Register view: word index and byte lane inside a peripheral
    typedef struct packed {
        logic [`PE_ADDR_W-7:0] upper;
        logic [3:0]            reg_off;
        logic [1:0]            lane;
    } reg_view_t;

    // Same address word, seen by the decoder or by a peripheral
    typedef union packed {
        rgn_view_t rgn;
        reg_view_t regs;
    } bus_addr_u;

endpackage

/* periph_bus_if.sv */
`timescale 1ns/1ps

`include "pe_bus_cfg.svh"

interface periph_bus_if
    import pe_bus_pkg::*;
();

    logic                  en;
    logic [3:0]            we;
    bus_addr_u             addr;
    logic [`PE_DATA_W-1:0] wdata;
    // Registered by the peripheral, valid the cycle after en
    logic [`PE_DATA_W-1:0] rdata;

    modport dec (
        output en,
        output we,
        output addr,
        output wdata,
        input  rdata
    );

    modport periph (
        input  en,
        input  we,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

/* pe_addr_decoder.sv */
`timescale 1ns/1ps

`include "pe_bus_cfg.svh"

module pe_addr_decoder
    import pe_bus_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  cpu_en_i,
    input  logic [3:0]            cpu_we_i,
    input  bus_addr_u             cpu_addr_i,
    input  logic [`PE_DATA_W-1:0] cpu_wdata_i,
    input  logic [`PE_DATA_W-1:0] dmem_rdata_i,
    input  logic [`PE_DATA_W-1:0] ni_rdata_i,
    output logic                  dmem_en_o,
    output logic                  ni_en_o,
    output logic [`PE_DATA_W-1:0] cpu_rdata_o,
    periph_bus_if.dec             rtc_bus,
    periph_bus_if.dec             plic_bus
);

    logic [7:0] region;
    logic       rtc_sel_q;
    logic       plic_sel_q;
    logic       ni_sel_q;

    ////////////////////////////////////////////////////////////////////////////
    // Region decode
    ////////////////////////////////////////////////////////////////////////////

    assign region = cpu_addr_i.rgn.region;

    assign dmem_en_o   = cpu_en_i && (region == `PE_RGN_DMEM);
    assign ni_en_o     = cpu_en_i && (region == `PE_RGN_NI);
    assign rtc_bus.en  = cpu_en_i && (region == `PE_RGN_RTC);
    assign plic_bus.en = cpu_en_i && (region == `PE_RGN_PLIC);

    // Write side is shared by both peripherals
    assign rtc_bus.we     = cpu_we_i;
    assign rtc_bus.addr   = cpu_addr_i;
    assign rtc_bus.wdata  = cpu_wdata_i;
    assign plic_bus.we    = cpu_we_i;
    assign plic_bus.addr  = cpu_addr_i;
    assign plic_bus.wdata = cpu_wdata_i;

    ////////////////////////////////////////////////////////////////////////////
    // Read return, one cycle after the strobe
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rtc_sel_q  <= 1'b0;
            plic_sel_q <= 1'b0;
            ni_sel_q   <= 1'b0;
        end else begin
            rtc_sel_q  <= rtc_bus.en;
            plic_sel_q <= plic_bus.en;
            ni_sel_q   <= ni_en_o;
        end
    end

    // Data memory is the fallback source
    always_comb begin
        if (rtc_sel_q) begin
            cpu_rdata_o = rtc_bus.rdata;
        end else if (plic_sel_q) begin
            cpu_rdata_o = plic_bus.rdata;
        end else if (ni_sel_q) begin
            cpu_rdata_o = ni_rdata_i;
        end else begin
            cpu_rdata_o = dmem_rdata_i;
        end
    end

    a_one_region : assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({dmem_en_o, ni_en_o, rtc_bus.en, plic_bus.en}));

endmodule

/* pe_rtc.sv */
`timescale 1ns/1ps

`include "pe_bus_cfg.svh"

module pe_rtc (
    input  logic          clk_i,
    input  logic          rst_ni,
    output logic [63:0]   mtime_o,
    output logic          mti_o,
    periph_bus_if.periph  bus
);

    // Word indices of the registers
    localparam logic [3:0] mtime_lo_w = 4'(`PE_RTC_MTIME_LO >> 2);
    localparam logic [3:0] mtime_hi_w = 4'(`PE_RTC_MTIME_HI >> 2);
    localparam logic [3:0] cmp_lo_w   = 4'(`PE_RTC_CMP_LO >> 2);
    localparam logic [3:0] cmp_hi_w   = 4'(`PE_RTC_CMP_HI >> 2);

    logic [63:0]           mtime_q;
    logic [63:0]           mtime_d;
    logic [63:0]           cmp_q;
    logic [63:0]           cmp_d;
    logic                  wr;
    logic                  rd;
    logic [`PE_DATA_W-1:0] rword;
    logic [`PE_DATA_W-1:0] rdata_q;

    // Replace only the bytes with their lane strobe set
    function automatic logic [31:0] merge_bytes(input logic [31:0] cur,
                                                input logic [31:0] wdata,
                                                input logic [3:0]  be);
        logic [31:0] res;
        res = cur;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                res[8*i +: 8] = wdata[8*i +: 8];
            end
        end
        return res;
    endfunction

    assign wr = bus.en && (bus.we != 4'b0000);
    assign rd = bus.en && (bus.we == 4'b0000);

    ////////////////////////////////////////////////////////////////////////////
    // Register access
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        mtime_d = mtime_q + 64'd1;
        cmp_d   = cmp_q;
        rword   = '0;
        case (bus.addr.regs.reg_off)
            mtime_lo_w: begin
                rword = mtime_q[31:0];
                if (wr) begin
                    // Upper half holds, no carry from the written word
                    mtime_d = {mtime_q[63:32], merge_bytes(mtime_q[31:0], bus.wdata, bus.we)};
                end
            end
            mtime_hi_w: begin
                rword = mtime_q[63:32];
                if (wr) begin
                    mtime_d[63:32] = merge_bytes(mtime_q[63:32], bus.wdata, bus.we);
                end
            end
            cmp_lo_w: begin
                rword = cmp_q[31:0];
                if (wr) begin
                    cmp_d[31:0] = merge_bytes(cmp_q[31:0], bus.wdata, bus.we);
                end
            end
            cmp_hi_w: begin
                rword = cmp_q[63:32];
                if (wr) begin
                    cmp_d[63:32] = merge_bytes(cmp_q[63:32], bus.wdata, bus.we);
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mtime_q <= '0;
            cmp_q   <= '1;
        end else begin
            mtime_q <= mtime_d;
            cmp_q   <= cmp_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd) begin
            rdata_q <= rword;
        end
    end

    assign bus.rdata = rdata_q;
    assign mtime_o   = mtime_q;
    assign mti_o     = (mtime_q >= cmp_q);

    // Counter advances by one in every cycle without a write
    a_mtime_count : assert property (@(posedge clk_i) disable iff (!rst_ni)
        !wr |=> (mtime_q == $past(mtime_q) + 64'd1));

endmodule

/* pe_plic.sv */
`timescale 1ns/1ps

`include "pe_bus_cfg.svh"

module pe_plic (
    input  logic          clk_i,
    input  logic          rst_ni,
    input  logic          ext_irq_i,
    input  logic          irq_ack_i,
    output logic          mei_o,
    periph_bus_if.periph  bus
);

    localparam logic [3:0] enable_w  = 4'(`PE_PLIC_ENABLE >> 2);
    localparam logic [3:0] pending_w = 4'(`PE_PLIC_PENDING >> 2);

    logic                  irq_q;
    logic                  irq_rise;
    logic                  pending_q;
    logic                  enable_q;
    logic                  wr;
    logic                  rd;
    logic [`PE_DATA_W-1:0] rdata_q;

    assign irq_rise = ext_irq_i && !irq_q;
    assign wr       = bus.en && (bus.we != 4'b0000);
    assign rd       = bus.en && (bus.we == 4'b0000);

    ////////////////////////////////////////////////////////////////////////////
    // Source edge, enable and pending
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            irq_q     <= 1'b0;
            pending_q <= 1'b0;
            enable_q  <= 1'b0;
        end else begin
            irq_q <= ext_irq_i;
            if (wr && (bus.addr.regs.reg_off == enable_w) && bus.we[0]) begin
                enable_q <= bus.wdata[0];
            end
            // A new edge wins over a clear in the same cycle
            if (irq_rise) begin
                pending_q <= 1'b1;
            end else if (irq_ack_i || (wr && (bus.addr.regs.reg_off == pending_w))) begin
                pending_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd) begin
            case (bus.addr.regs.reg_off)
                enable_w:  rdata_q <= {{(`PE_DATA_W-1){1'b0}}, enable_q};
                pending_w: rdata_q <= {{(`PE_DATA_W-1){1'b0}}, pending_q};
                default:   rdata_q <= '0;
            endcase
        end
    end

    assign bus.rdata = rdata_q;
    assign mei_o     = pending_q && enable_q;

    // Masked source stays quiet until enable is written
    a_mei_enabled : assert property (@(posedge clk_i) disable iff (!rst_ni)
        (!enable_q && !(wr && (bus.addr.regs.reg_off == enable_w)))
        |=> !mei_o);

endmodule

/* pe_dma_bank_mux.sv */
`timescale 1ns/1ps

`include "pe_bus_cfg.svh"

module pe_dma_bank_mux
    import pe_bus_pkg::*;
(
    input  logic                  dma_en_i,
    input  bus_addr_u             dma_addr_i,
    input  logic [`PE_DATA_W-1:0] imem_rdata_i,
    input  logic [`PE_DATA_W-1:0] dmem_rdata_i,
    output logic                  imem_dma_en_o,
    output logic                  dmem_dma_en_o,
    output logic [`PE_DATA_W-1:0] dma_rdata_o
);

    logic [7:0] bank;

    // Bank code shares the top byte with the CPU region code
    assign bank = dma_addr_i.rgn.region;

    assign imem_dma_en_o = dma_en_i && (bank == `PE_BANK_IMEM);
    assign dmem_dma_en_o = dma_en_i && (bank == `PE_BANK_DMEM);

    always_comb begin
        case (bank)
            `PE_BANK_IMEM: dma_rdata_o = imem_rdata_i;
            `PE_BANK_DMEM: dma_rdata_o = dmem_rdata_i;
            default:       dma_rdata_o = '0;
        endcase
    end

    always_comb begin
        a_one_bank : assert (!(imem_dma_en_o && dmem_dma_en_o));
    end

endmodule

/* pe_bus_fabric.sv */
`timescale 1ns/1ps

`include "pe_bus_cfg.svh"

module pe_bus_fabric
    import pe_bus_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  cpu_en_i,
    input  logic [3:0]            cpu_we_i,
    input  logic [`PE_ADDR_W-1:0] cpu_addr_i,
    input  logic [`PE_DATA_W-1:0] cpu_wdata_i,
    input  logic [`PE_DATA_W-1:0] dmem_rdata_i,
    input  logic [`PE_DATA_W-1:0] ni_rdata_i,
    input  logic                  ext_irq_i,
    input  logic                  irq_ack_i,
    input  logic                  dma_en_i,
    input  logic [`PE_ADDR_W-1:0] dma_addr_i,
    input  logic [`PE_DATA_W-1:0] imem_dma_rdata_i,
    input  logic [`PE_DATA_W-1:0] dmem_dma_rdata_i,
    output logic [`PE_DATA_W-1:0] cpu_rdata_o,
    output logic                  dmem_en_o,
    output logic [`PE_OFFS_W-1:0] dmem_addr_o,
    output logic                  ni_en_o,
    output logic [63:0]           mtime_o,
    output logic [31:0]           irq_o,
    output logic                  imem_dma_en_o,
    output logic                  dmem_dma_en_o,
    output logic [`PE_OFFS_W-1:0] dma_addr_o,
    output logic [`PE_DATA_W-1:0] dma_rdata_o
);

    bus_addr_u cpu_addr;
    bus_addr_u dma_addr;
    logic      mti;
    logic      mei;

    periph_bus_if rtc_bus ();
    periph_bus_if plic_bus ();

    assign cpu_addr = cpu_addr_i;
    assign dma_addr = dma_addr_i;

    // Memories only see the offset inside their region
    assign dmem_addr_o = cpu_addr.rgn.offset;
    assign dma_addr_o  = dma_addr.rgn.offset;

    ////////////////////////////////////////////////////////////////////////////
    // Core bus side
    ////////////////////////////////////////////////////////////////////////////

    pe_addr_decoder i_decoder (
        .clk_i       (clk_i       ),
        .rst_ni      (rst_ni      ),
        .cpu_en_i    (cpu_en_i    ),
        .cpu_we_i    (cpu_we_i    ),
        .cpu_addr_i  (cpu_addr    ),
        .cpu_wdata_i (cpu_wdata_i ),
        .dmem_rdata_i(dmem_rdata_i),
        .ni_rdata_i  (ni_rdata_i  ),
        .dmem_en_o   (dmem_en_o   ),
        .ni_en_o     (ni_en_o     ),
        .cpu_rdata_o (cpu_rdata_o ),
        .rtc_bus     (rtc_bus     ),
        .plic_bus    (plic_bus    )
    );

    pe_rtc i_rtc (
        .clk_i  (clk_i  ),
        .rst_ni (rst_ni ),
        .mtime_o(mtime_o),
        .mti_o  (mti    ),
        .bus    (rtc_bus)
    );

    pe_plic i_plic (
        .clk_i    (clk_i    ),
        .rst_ni   (rst_ni   ),
        .ext_irq_i(ext_irq_i),
        .irq_ack_i(irq_ack_i),
        .mei_o    (mei      ),
        .bus      (plic_bus )
    );

    // Machine timer and machine external lines of the vector
    always_comb begin
        irq_o                  = '0;
        irq_o[`PE_IRQ_MTI_BIT] = mti;
        irq_o[`PE_IRQ_MEI_BIT] = mei;
    end

    ////////////////////////////////////////////////////////////////////////////
    // DMA side
    ////////////////////////////////////////////////////////////////////////////

    pe_dma_bank_mux i_dma_mux (
        .dma_en_i     (dma_en_i        ),
        .dma_addr_i   (dma_addr        ),
        .imem_rdata_i (imem_dma_rdata_i),
        .dmem_rdata_i (dmem_dma_rdata_i),
        .imem_dma_en_o(imem_dma_en_o   ),
        .dmem_dma_en_o(dmem_dma_en_o   ),
        .dma_rdata_o  (dma_rdata_o     )
    );

endmodule

/* tb_pe_bus_fabric.sv */
`timescale 1ns/1ps

module tb_pe_bus_fabric;

    logic        clk_i;
    logic        rst_ni;
    logic        cpu_en_i;
    logic [3:0]  cpu_we_i;
    logic [31:0] cpu_addr_i;
    logic [31:0] cpu_wdata_i;
    logic [31:0] dmem_rdata_i;
    logic [31:0] ni_rdata_i;
    logic        ext_irq_i;
    logic        irq_ack_i;
    logic        dma_en_i;
    logic [31:0] dma_addr_i;
    logic [31:0] imem_dma_rdata_i;
    logic [31:0] dmem_dma_rdata_i;
    logic [31:0] cpu_rdata_o;
    logic        dmem_en_o;
    logic [23:0] dmem_addr_o;
    logic        ni_en_o;
    logic [63:0] mtime_o;
    logic [31:0] irq_o;
    logic        imem_dma_en_o;
    logic        dmem_dma_en_o;
    logic [23:0] dma_addr_o;
    logic [31:0] dma_rdata_o;

    // Stimulus table, one bus access per row
    localparam int n_rows = 8;
    logic        tab_wr    [n_rows];
    logic [31:0] tab_addr  [n_rows];
    logic [31:0] tab_wdata [n_rows];
    logic [31:0] tab_exp   [n_rows];
    logic        tab_chk   [n_rows];

    logic [31:0] rng;
    logic [31:0] dm_word;
    logic [31:0] ni_word;
    logic [31:0] cmp_lo;
    logic [31:0] cmp_hi;
    logic [31:0] imem_word;
    logic [31:0] dram_word;
    logic [31:0] rdata;
    logic [63:0] t_start;
    int          errors;
    int          checks;

    pe_bus_fabric i_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_word();
        rng = xorshift32(rng);
        return rng;
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Bus access helpers
    ////////////////////////////////////////////////////////////////////////////

    // Enable for one cycle, read data is taken in the cycle after
    task automatic bus_access(input logic wr, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rd);
        @(posedge clk_i);
        cpu_en_i    <= 1'b1;
        cpu_we_i    <= wr ? 4'hf : 4'h0;
        cpu_addr_i  <= addr;
        cpu_wdata_i <= wdata;
        @(negedge clk_i);
        check("dmem_en_o", 64'(dmem_en_o), 64'(addr[31:24] == 8'h01));
        check("ni_en_o", 64'(ni_en_o), 64'(addr[31:24] == 8'h08));
        if (addr[31:24] == 8'h01) begin
            check("dmem_addr_o", 64'(dmem_addr_o), 64'(addr[23:0]));
        end
        @(posedge clk_i);
        cpu_en_i <= 1'b0;
        cpu_we_i <= 4'h0;
        @(negedge clk_i);
        rd = cpu_rdata_o;
    endtask

    task automatic wait_irq(input int idx, input logic level, input string what);
        int n;
        n = 0;
        while (irq_o[idx] !== level && n < 50) begin
            @(negedge clk_i);
            n++;
        end
        if (irq_o[idx] !== level) begin
            errors++;
            $display("Timeout: irq_o bit %0d did not go to %0b %s", idx, level, what);
        end
    endtask

    task automatic pulse_ext_irq();
        @(posedge clk_i);
        ext_irq_i <= 1'b1;
        @(posedge clk_i);
        ext_irq_i <= 1'b0;
        @(negedge clk_i);
    endtask

    task automatic pulse_ack();
        @(posedge clk_i);
        irq_ack_i <= 1'b1;
        @(posedge clk_i);
        irq_ack_i <= 1'b0;
        @(negedge clk_i);
    endtask

    task automatic dma_probe(input logic [7:0] bank, input logic exp_imem,
                             input logic exp_dmem, input logic [31:0] exp_data);
        logic [23:0] off;
        off = 24'(next_word());
        @(posedge clk_i);
        dma_en_i   <= 1'b1;
        dma_addr_i <= {bank, off};
        @(negedge clk_i);
        check("imem_dma_en_o", 64'(imem_dma_en_o), 64'(exp_imem));
        check("dmem_dma_en_o", 64'(dmem_dma_en_o), 64'(exp_dmem));
        check("dma_rdata_o", 64'(dma_rdata_o), 64'(exp_data));
        check("dma_addr_o", 64'(dma_addr_o), 64'(off));
        @(posedge clk_i);
        dma_en_i <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        errors           = 0;
        checks           = 0;
        rng              = 32'h84ccc26c;
        rst_ni           <= 1'b0;
        cpu_en_i         <= 1'b0;
        cpu_we_i         <= 4'h0;
        cpu_addr_i       <= '0;
        cpu_wdata_i      <= '0;
        dmem_rdata_i     <= '0;
        ni_rdata_i       <= '0;
        ext_irq_i        <= 1'b0;
        irq_ack_i        <= 1'b0;
        dma_en_i         <= 1'b0;
        dma_addr_i       <= '0;
        imem_dma_rdata_i <= '0;
        dmem_dma_rdata_i <= '0;
        repeat (3) @(posedge clk_i);
        rst_ni <= 1'b1;

        dm_word   = next_word();
        ni_word   = next_word();
        cmp_lo    = next_word();
        cmp_hi    = next_word();
        imem_word = next_word();
        dram_word = next_word();
        dmem_rdata_i     <= dm_word;
        ni_rdata_i       <= ni_word;
        imem_dma_rdata_i <= imem_word;
        dmem_dma_rdata_i <= dram_word;

        // Passthrough regions, then RTC compare and controller enable
        tab_wr = '{0, 0, 1, 1, 0, 0, 0, 0};
        tab_addr = '{32'h0100_0040, 32'h0800_0010, 32'h0200_0008, 32'h0200_000C,
                     32'h0200_0008, 32'h0200_000C, 32'h0400_0000, 32'h01FF_FFFC};
        tab_wdata = '{32'h0, 32'h0, cmp_lo, cmp_hi, 32'h0, 32'h0, 32'h0, 32'h0};
        tab_exp = '{dm_word, ni_word, 32'h0, 32'h0, cmp_lo, cmp_hi, 32'h0, dm_word};
        tab_chk = '{1, 1, 0, 0, 1, 1, 1, 1};

        @(negedge clk_i);
        t_start = mtime_o;
        for (int i = 0; i < n_rows; i++) begin
            bus_access(tab_wr[i], tab_addr[i], tab_wdata[i], rdata);
            if (tab_chk[i]) begin
                check("cpu_rdata_o", 64'(rdata), 64'(tab_exp[i]));
            end
        end
        check("mtime_o increasing", 64'(mtime_o > t_start), 64'd1);

        // Timer interrupt follows the compare value
        bus_access(1'b1, 32'h0200_0008, 32'h0, rdata);
        bus_access(1'b1, 32'h0200_000C, 32'h0, rdata);
        wait_irq(7, 1'b1, "after compare cleared");
        check("irq_o", 64'(irq_o), 64'h0000_0080);
        bus_access(1'b1, 32'h0200_000C, 32'hFFFF_FFFF, rdata);
        bus_access(1'b1, 32'h0200_0008, 32'hFFFF_FFFF, rdata);
        wait_irq(7, 1'b0, "after compare set to all ones");

        // External interrupt, masked first
        pulse_ext_irq();
        bus_access(1'b0, 32'h0400_0004, 32'h0, rdata);
        check("pending", 64'(rdata), 64'd1);
        check("irq_o[11] masked", 64'(irq_o[11]), 64'd0);
        bus_access(1'b1, 32'h0400_0000, 32'h1, rdata);
        wait_irq(11, 1'b1, "after enable");
        check("irq_o", 64'(irq_o), 64'h0000_0800);
        pulse_ack();
        wait_irq(11, 1'b0, "after acknowledge");
        bus_access(1'b0, 32'h0400_0004, 32'h0, rdata);
        check("pending", 64'(rdata), 64'd0);

        // DMA bank steering
        dma_probe(8'h00, 1'b1, 1'b0, imem_word);
        dma_probe(8'h01, 1'b0, 1'b1, dram_word);
        dma_probe(8'h05, 1'b0, 1'b0, 32'h0);

        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* pe_bus_fabric.f */
+incdir+.
pe_bus_pkg.sv
periph_bus_if.sv
pe_addr_decoder.sv
pe_rtc.sv
pe_plic.sv
pe_dma_bank_mux.sv
pe_bus_fabric.sv
tb_pe_bus_fabric.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the fabric testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f pe_bus_fabric.f --top-module tb_pe_bus_fabric -o tb_pe_bus_fabric
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_pe_bus_fabric > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^PASS: all tests$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
